/* sim.f */
+incdir+verif
verilog/tlb_pkg.sv
verilog/tlb_entry_store.sv
verilog/tlb_match_stage.sv
verilog/tlb_select_stage.sv
verilog/tlb_top.sv
verif/tlb_tb.sv

/* Bender.yml */
package:
  name: tlb

sources:
  - verilog/tlb_pkg.sv
  - verilog/tlb_entry_store.sv
  - verilog/tlb_match_stage.sv
  - verilog/tlb_select_stage.sv
  - verilog/tlb_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tlb_tb.sv

/* verif/tlb_tb_table.svh */
localparam int max_rows = 600;

localparam logic [1:0] k_write  = 2'd0;
localparam logic [1:0] k_inv    = 2'd1;
localparam logic [1:0] k_lookup = 2'd2;
localparam logic [1:0] k_read   = 2'd3;

// one row per operation
// lookup rows keep the expected page half in the *0 fields and found in e
typedef struct packed {
    logic [1:0] kind;
    tlb_index_t index;
    logic       e;
    logic       full;
    vppn_t      vppn;
    ps_t        ps;
    asid_t      asid;
    logic       g;
    logic       bit12;
    inv_op_t    op;
    ppn_t       ppn0;
    ppn_t       ppn1;
    plv_t       plv0;
    plv_t       plv1;
    mat_t       mat0;
    mat_t       mat1;
    logic       d0;
    logic       d1;
    logic       v0;
    logic       v1;
} row_t;

row_t        rows[max_rows];
int          row_count = 0;
// expected contents of every entry while the table is built
row_t        model[tlb_num];
logic [15:0] lfsr_state;

// galois lfsr, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
        val = {val[30:0], lfsr_state[0]};
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
        else
            lfsr_state = lfsr_state >> 1;
    end
    return val;
endfunction

// a 4 MB double page spans 1024 vppn values
function automatic logic covers(input row_t ent, input vppn_t va);
    if (ent.ps == ps_4m)
        return ent.vppn[18:10] == va[18:10];
    return ent.vppn == va;
endfunction

task automatic add_row(input row_t row);
    rows[row_count] = row;
    row_count++;
endtask

task automatic add_write(input int idx, input logic e, input logic huge,
                         input logic g, input asid_t asid);
    row_t row;
    row       = '0;
    row.kind  = k_write;
    row.index = tlb_index_t'(idx);
    row.e     = e;
    row.full  = 1'b1;
    // top four vppn bits carry the index so entries never overlap
    row.vppn  = {tlb_index_t'(idx), 15'(lfsr_bits(15))};
    row.ps    = huge ? ps_4m : ps_4k;
    row.asid  = asid;
    row.g     = g;
    row.ppn0  = ppn_t'(lfsr_bits(20));
    row.ppn1  = ppn_t'(lfsr_bits(20));
    {row.plv0, row.plv1, row.mat0, row.mat1} = 8'(lfsr_bits(8));
    {row.d0, row.d1, row.v0, row.v1} = 4'(lfsr_bits(4));
    model[idx] = row;
    add_row(row);
endtask

task automatic add_inv(input inv_op_t op, input asid_t asid, input vppn_t va);
    row_t row;
    logic same;
    logic clr;
    row      = '0;
    row.kind = k_inv;
    row.op   = op;
    row.asid = asid;
    row.vppn = va;
    add_row(row);
    for (int i = 0; i < tlb_num; i++)
    begin
        same = (model[i].asid == asid);
        case (op)
            inv_all0, inv_all1: clr = 1'b1;
            inv_global:         clr = model[i].g;
            inv_nonglobal:      clr = !model[i].g;
            inv_asid:           clr = !model[i].g && same;
            inv_asid_va:        clr = !model[i].g && same && covers(model[i], va);
            inv_g_or_asid_va:   clr = (model[i].g || same) && covers(model[i], va);
            default:            clr = 1'b0;
        endcase
        if (clr)
            model[i].e = 1'b0;
    end
endtask

task automatic add_lookup(input vppn_t va, input logic bit12, input asid_t asid);
    row_t row;
    logic odd;
    row       = '0;
    row.kind  = k_lookup;
    row.vppn  = va;
    row.bit12 = bit12;
    row.asid  = asid;
    for (int i = 0; i < tlb_num; i++)
    begin
        if (!row.e && model[i].e && covers(model[i], va)
            && (model[i].g || model[i].asid == asid))
        begin
            odd       = (model[i].ps == ps_4m) ? va[9] : bit12;
            row.e     = 1'b1;
            row.index = tlb_index_t'(i);
            row.ps    = model[i].ps;
            row.ppn0  = odd ? model[i].ppn1 : model[i].ppn0;
            row.plv0  = odd ? model[i].plv1 : model[i].plv0;
            row.mat0  = odd ? model[i].mat1 : model[i].mat0;
            row.d0    = odd ? model[i].d1 : model[i].d0;
            row.v0    = odd ? model[i].v1 : model[i].v0;
        end
    end
    add_row(row);
endtask

task automatic add_read(input int idx);
    row_t row;
    row       = model[idx];
    row.kind  = k_read;
    row.index = tlb_index_t'(idx);
    add_row(row);
endtask

/* verif/tlb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_tb
    import tlb_pkg::*;
();

    localparam int clk_period = 40;

    logic       clk;
    logic       rst_n;
    logic       we;
    tlb_index_t w_index;
    logic       w_e;
    vppn_t      w_vppn;
    ps_t        w_ps;
    asid_t      w_asid;
    logic       w_g;
    ppn_t       w_ppn0, w_ppn1;
    plv_t       w_plv0, w_plv1;
    mat_t       w_mat0, w_mat1;
    logic       w_d0, w_d1;
    logic       w_v0, w_v1;
    logic       inv_valid;
    inv_op_t    inv_op;
    asid_t      inv_asid;
    vppn_t      inv_vppn;
    tlb_index_t r_index;
    logic       r_e;
    vppn_t      r_vppn;
    ps_t        r_ps;
    asid_t      r_asid;
    logic       r_g;
    ppn_t       r_ppn0, r_ppn1;
    plv_t       r_plv0, r_plv1;
    mat_t       r_mat0, r_mat1;
    logic       r_d0, r_d1;
    logic       r_v0, r_v1;
    logic       lookup_valid;
    vppn_t      lookup_vppn;
    logic       lookup_va_bit12;
    asid_t      lookup_asid;
    logic       result_valid;
    logic       result_found;
    tlb_index_t result_index;
    ppn_t       result_ppn;
    ps_t        result_ps;
    plv_t       result_plv;
    mat_t       result_mat;
    logic       result_d;
    logic       result_v;

    `include "tlb_tb_table.svh"

    // lookups in flight and the cycle each result is due
    row_t pending[$];
    int   pending_due[$];
    int   cycle = 0;
    logic table_ready = 1'b0;

    tlb_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic expect_eq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("** Error at %0t: %s is %0h, expected %0h",
                                $time, what, got, exp));
    endtask

    // 13 written with e clear, 4 5 10 11 are 4 MB, 2 5 11 14 global
    task automatic fill_entries(input asid_t a, input asid_t b);
        for (int i = 0; i < tlb_num; i++)
        begin
            add_write(i, i != 13, i inside {4, 5, 10, 11}, i inside {2, 5, 11, 14},
                      (i % 2) ? b : a);
        end
    endtask

    task automatic build_table();
        asid_t   a;
        asid_t   b;
        asid_t   other;
        inv_op_t op;
        int      k;
        vppn_t   va;
        lfsr_state = 16'd44192;
        for (int i = 0; i < tlb_num; i++)
        begin
            model[i] = '0;
        end
        a = asid_t'(lfsr_bits(10));
        // b flips the top bit of a, other flips bit 0, so all three differ
        b     = a ^ {1'b1, 9'(lfsr_bits(9))};
        other = a ^ 10'h001;
        for (int i = 0; i < tlb_num; i++)
            add_read(i);
        fill_entries(a, b);
        for (int i = 0; i < tlb_num; i++)
            add_read(i);
        for (int i = 0; i < tlb_num; i++)
        begin
            add_lookup(model[i].vppn, 1'b0, model[i].asid);
            add_lookup(model[i].vppn, 1'b1, model[i].asid);
            add_lookup(model[i].vppn, 1'b0, other);
            // low ten bits are ignored by a 4 MB entry
            add_lookup({model[i].vppn[18:10], 10'(lfsr_bits(10))}, 1'b1, model[i].asid);
        end
        // ops 0 to 6, op 6 again via asid, then an unused code
        for (int j = 0; j < 9; j++)
        begin
            op = (j < 7) ? inv_op_t'(j) : ((j == 7) ? inv_g_or_asid_va : 5'd17);
            k  = (j == 6) ? 5 : ((j == 7) ? 0 : 4);
            fill_entries(a, b);
            va = model[k].vppn;
            if (model[k].ps == ps_4m)
                va[9:0] = 10'(lfsr_bits(10));
            add_inv(op, a, va);
            for (int i = 0; i < tlb_num; i++)
                add_read(i);
            for (int i = 0; i < tlb_num; i++)
                add_lookup(model[i].vppn, 1'(i % 2), model[i].asid);
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2;
        we           = 1'b0;
        inv_valid    = 1'b0;
        lookup_valid = 1'b0;
    endtask

    task automatic drive_row(input row_t row);
        idle_cycle();
        case (row.kind)
            k_write:
            begin
                we      = 1'b1;
                w_index = row.index;
                w_e     = row.e;
                w_vppn  = row.vppn;
                w_ps    = row.ps;
                w_asid  = row.asid;
                w_g     = row.g;
                w_ppn0  = row.ppn0;
                w_ppn1  = row.ppn1;
                w_plv0  = row.plv0;
                w_plv1  = row.plv1;
                w_mat0  = row.mat0;
                w_mat1  = row.mat1;
                w_d0    = row.d0;
                w_d1    = row.d1;
                w_v0    = row.v0;
                w_v1    = row.v1;
            end
            k_inv:
            begin
                inv_valid = 1'b1;
                inv_op    = row.op;
                inv_asid  = row.asid;
                inv_vppn  = row.vppn;
            end
            k_lookup:
            begin
                lookup_valid    = 1'b1;
                lookup_vppn     = row.vppn;
                lookup_va_bit12 = row.bit12;
                lookup_asid     = row.asid;
                pending.push_back(row);
                pending_due.push_back(cycle + 2);
            end
            default:
                r_index = row.index;
        endcase
    endtask

    task automatic check_read(input row_t row);
        expect_eq("r_e", r_e, row.e);
        if (row.full)
        begin
            expect_eq("r_vppn", r_vppn, row.vppn);
            expect_eq("r_ps", r_ps, row.ps);
            expect_eq("r_asid", r_asid, row.asid);
            expect_eq("r_g", r_g, row.g);
            expect_eq("r_ppn0", r_ppn0, row.ppn0);
            expect_eq("r_ppn1", r_ppn1, row.ppn1);
            expect_eq("r_plv0", r_plv0, row.plv0);
            expect_eq("r_plv1", r_plv1, row.plv1);
            expect_eq("r_mat0", r_mat0, row.mat0);
            expect_eq("r_mat1", r_mat1, row.mat1);
            expect_eq("r_d0", r_d0, row.d0);
            expect_eq("r_d1", r_d1, row.d1);
            expect_eq("r_v0", r_v0, row.v0);
            expect_eq("r_v1", r_v1, row.v1);
        end
    endtask

    task automatic check_lookup(input row_t row);
        expect_eq("result_found", result_found, row.e);
        expect_eq("result_index", result_index, row.index);
        expect_eq("result_ppn", result_ppn, row.ppn0);
        expect_eq("result_ps", result_ps, row.ps);
        expect_eq("result_plv", result_plv, row.plv0);
        expect_eq("result_mat", result_mat, row.mat0);
        expect_eq("result_d", result_d, row.d0);
        expect_eq("result_v", result_v, row.v0);
    endtask

    // results sampled mid-cycle, each must land exactly on its due cycle
    always @(negedge clk)
    begin
        if (rst_n === 1'b1)
        begin
            if (result_valid === 1'b1)
            begin
                assert (pending.size() > 0)
                else
                    abort_run("result_valid was set with no lookup in flight");
                assert (pending_due[0] == cycle)
                else
                    abort_run("a lookup result arrived on the wrong cycle");
                check_lookup(pending.pop_front());
                void'(pending_due.pop_front());
            end
            else
            begin
                assert (result_valid === 1'b0)
                else
                    abort_run("result_valid is unknown after reset");
                assert (pending.size() == 0 || pending_due[0] != cycle)
                else
                    abort_run("a lookup result did not arrive two cycles after its lookup");
            end
        end
    end

    initial
    begin
        wait (table_ready);
        // ten cycles per row leaves a wide margin
        #(row_count * 10 * clk_period);
        abort_run("timeout, the stimulus table did not complete in time");
    end

    initial
    begin
        rst_n           = 1'b0;
        we              = 1'b0;
        w_index         = '0;
        w_e             = 1'b0;
        w_vppn          = '0;
        w_ps            = ps_4k;
        w_asid          = '0;
        w_g             = 1'b0;
        w_ppn0          = '0;
        w_ppn1          = '0;
        w_plv0          = '0;
        w_plv1          = '0;
        w_mat0          = '0;
        w_mat1          = '0;
        w_d0            = 1'b0;
        w_d1            = 1'b0;
        w_v0            = 1'b0;
        w_v1            = 1'b0;
        inv_valid       = 1'b0;
        inv_op          = '0;
        inv_asid        = '0;
        inv_vppn        = '0;
        r_index         = '0;
        lookup_valid    = 1'b0;
        lookup_vppn     = '0;
        lookup_va_bit12 = 1'b0;
        lookup_asid     = '0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int n = 0; n < row_count; n++)
        begin
            // store changes only once no lookup is in flight
            if (rows[n].kind == k_write || rows[n].kind == k_inv)
            begin
                while (pending.size() > 0)
                    idle_cycle();
            end
            drive_row(rows[n]);
            if (rows[n].kind == k_read)
            begin
                @(negedge clk);
                check_read(rows[n]);
            end
            else if (rows[n].kind != k_lookup)
            begin
                idle_cycle();
                idle_cycle();
            end
        end
        idle_cycle();
        while (pending.size() > 0)
            idle_cycle();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/tlb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_top
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         we,
    input  wire tlb_index_t             w_index,
    input  wire                         w_e,
    input  wire vppn_t                  w_vppn,
    input  wire ps_t                    w_ps,
    input  wire asid_t                  w_asid,
    input  wire                         w_g,
    input  wire ppn_t                   w_ppn0,
    input  wire ppn_t                   w_ppn1,
    input  wire plv_t                   w_plv0,
    input  wire plv_t                   w_plv1,
    input  wire mat_t                   w_mat0,
    input  wire mat_t                   w_mat1,
    input  wire                         w_d0,
    input  wire                         w_d1,
    input  wire                         w_v0,
    input  wire                         w_v1,
    input  wire                         inv_valid,
    input  wire inv_op_t                inv_op,
    input  wire asid_t                  inv_asid,
    input  wire vppn_t                  inv_vppn,
    input  wire tlb_index_t             r_index,
    output logic                        r_e,
    output vppn_t                       r_vppn,
    output ps_t                         r_ps,
    output asid_t                       r_asid,
    output logic                        r_g,
    output ppn_t                        r_ppn0,
    output ppn_t                        r_ppn1,
    output plv_t                        r_plv0,
    output plv_t                        r_plv1,
    output mat_t                        r_mat0,
    output mat_t                        r_mat1,
    output logic                        r_d0,
    output logic                        r_d1,
    output logic                        r_v0,
    output logic                        r_v1,
    input  wire                         lookup_valid,
    input  wire vppn_t                  lookup_vppn,
    input  wire                         lookup_va_bit12,
    input  wire asid_t                  lookup_asid,
    output logic                        result_valid,
    output logic                        result_found,
    output tlb_index_t                  result_index,
    output ppn_t                        result_ppn,
    output ps_t                         result_ps,
    output plv_t                        result_plv,
    output mat_t                        result_mat,
    output logic                        result_d,
    output logic                        result_v
);

    // entry state, fanned out from the store to both stages
    logic  [tlb_num-1:0] entry_e;
    logic  [tlb_num-1:0] entry_huge;
    vppn_t [tlb_num-1:0] entry_vppn;
    asid_t [tlb_num-1:0] entry_asid;
    logic  [tlb_num-1:0] entry_g;
    ppn_t  [tlb_num-1:0] entry_ppn0;
    ppn_t  [tlb_num-1:0] entry_ppn1;
    plv_t  [tlb_num-1:0] entry_plv0;
    plv_t  [tlb_num-1:0] entry_plv1;
    mat_t  [tlb_num-1:0] entry_mat0;
    mat_t  [tlb_num-1:0] entry_mat1;
    logic  [tlb_num-1:0] entry_d0;
    logic  [tlb_num-1:0] entry_d1;
    logic  [tlb_num-1:0] entry_v0;
    logic  [tlb_num-1:0] entry_v1;

    // stage 1 to stage 2
    logic                s1_valid;
    logic  [tlb_num-1:0] s1_hit;
    logic  [tlb_num-1:0] s1_odd;

    tlb_entry_store u_store (.*);

    tlb_match_stage u_match (.*);

    tlb_select_stage u_select (.*);

endmodule

`default_nettype wire

/* verilog/tlb_select_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_select_stage
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         s1_valid,
    input  wire [tlb_num-1:0]           s1_hit,
    input  wire [tlb_num-1:0]           s1_odd,
    input  wire [tlb_num-1:0]           entry_huge,
    input  wire ppn_t [tlb_num-1:0]     entry_ppn0,
    input  wire ppn_t [tlb_num-1:0]     entry_ppn1,
    input  wire plv_t [tlb_num-1:0]     entry_plv0,
    input  wire plv_t [tlb_num-1:0]     entry_plv1,
    input  wire mat_t [tlb_num-1:0]     entry_mat0,
    input  wire mat_t [tlb_num-1:0]     entry_mat1,
    input  wire [tlb_num-1:0]           entry_d0,
    input  wire [tlb_num-1:0]           entry_d1,
    input  wire [tlb_num-1:0]           entry_v0,
    input  wire [tlb_num-1:0]           entry_v1,
    output logic                        result_valid,
    output logic                        result_found,
    output tlb_index_t                  result_index,
    output ppn_t                        result_ppn,
    output ps_t                         result_ps,
    output plv_t                        result_plv,
    output mat_t                        result_mat,
    output logic                        result_d,
    output logic                        result_v
);

    logic       sel_found;
    tlb_index_t sel_index;
    ppn_t       nxt_ppn;
    ps_t        nxt_ps;
    plv_t       nxt_plv;
    mat_t       nxt_mat;
    logic       nxt_d;
    logic       nxt_v;

    // priority encode, scanned downwards so the lowest index wins
    always_comb
    begin
        sel_found = 1'b0;
        sel_index = '0;
        for (int i = tlb_num - 1; i >= 0; i--)
        begin
            if (s1_hit[i])
            begin
                sel_found = 1'b1;
                sel_index = tlb_index_t'(i);
            end
        end
    end

    // miss leaves every field at zero
    always_comb
    begin
        nxt_ppn = '0;
        nxt_ps  = '0;
        nxt_plv = '0;
        nxt_mat = '0;
        nxt_d   = 1'b0;
        nxt_v   = 1'b0;
        if (sel_found)
        begin
            nxt_ps = entry_huge[sel_index] ? ps_4m : ps_4k;
            if (s1_odd[sel_index])
            begin
                nxt_ppn = entry_ppn1[sel_index];
                nxt_plv = entry_plv1[sel_index];
                nxt_mat = entry_mat1[sel_index];
                nxt_d   = entry_d1[sel_index];
                nxt_v   = entry_v1[sel_index];
            end
            else
            begin
                nxt_ppn = entry_ppn0[sel_index];
                nxt_plv = entry_plv0[sel_index];
                nxt_mat = entry_mat0[sel_index];
                nxt_d   = entry_d0[sel_index];
                nxt_v   = entry_v0[sel_index];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            result_valid <= 1'b0;
        else
            result_valid <= s1_valid;
    end

    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            result_found <= sel_found;
            result_index <= sel_index;
            result_ppn   <= nxt_ppn;
            result_ps    <= nxt_ps;
            result_plv   <= nxt_plv;
            result_mat   <= nxt_mat;
            result_d     <= nxt_d;
            result_v     <= nxt_v;
        end
    end

    // software must never load two entries that match the same address
    a_unique_hit: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid |-> $onehot0(s1_hit));

endmodule

`default_nettype wire

/* verilog/tlb_match_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_match_stage
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         lookup_valid,
    input  wire vppn_t                  lookup_vppn,
    input  wire                         lookup_va_bit12,
    input  wire asid_t                  lookup_asid,
    input  wire [tlb_num-1:0]           entry_e,
    input  wire [tlb_num-1:0]           entry_huge,
    input  wire vppn_t [tlb_num-1:0]    entry_vppn,
    input  wire asid_t [tlb_num-1:0]    entry_asid,
    input  wire [tlb_num-1:0]           entry_g,
    output logic                        s1_valid,
    output logic [tlb_num-1:0]          s1_hit,
    output logic [tlb_num-1:0]          s1_odd
);

    logic [tlb_num-1:0] hit;
    logic [tlb_num-1:0] odd;

    // full parallel compare, one candidate per entry
    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            hit[i] = entry_e[i]
                && vppn_match(entry_vppn[i], entry_huge[i], lookup_vppn)
                && (entry_g[i] || (entry_asid[i] == lookup_asid));
            // page half is picked by a different address bit per page size
            odd[i] = entry_huge[i] ? lookup_vppn[odd_bit_4m] : lookup_va_bit12;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= lookup_valid;
    end

    // hit and odd vectors only meaningful alongside s1_valid
    always_ff @(posedge clk)
    begin
        if (lookup_valid)
        begin
            s1_hit <= hit;
            s1_odd <= odd;
        end
    end

endmodule

`default_nettype wire

/* verilog/tlb_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module tlb_entry_store
    import tlb_pkg::*;
(
    input  wire                         clk,
    input  wire                         rst_n,
    // write port
    input  wire                         we,
    input  wire tlb_index_t             w_index,
    input  wire                         w_e,
    input  wire vppn_t                  w_vppn,
    input  wire ps_t                    w_ps,
    input  wire asid_t                  w_asid,
    input  wire                         w_g,
    input  wire ppn_t                   w_ppn0,
    input  wire ppn_t                   w_ppn1,
    input  wire plv_t                   w_plv0,
    input  wire plv_t                   w_plv1,
    input  wire mat_t                   w_mat0,
    input  wire mat_t                   w_mat1,
    input  wire                         w_d0,
    input  wire                         w_d1,
    input  wire                         w_v0,
    input  wire                         w_v1,
    // invalidate
    input  wire                         inv_valid,
    input  wire inv_op_t                inv_op,
    input  wire asid_t                  inv_asid,
    input  wire vppn_t                  inv_vppn,
    // read port
    input  wire tlb_index_t             r_index,
    output logic                        r_e,
    output vppn_t                       r_vppn,
    output ps_t                         r_ps,
    output asid_t                       r_asid,
    output logic                        r_g,
    output ppn_t                        r_ppn0,
    output ppn_t                        r_ppn1,
    output plv_t                        r_plv0,
    output plv_t                        r_plv1,
    output mat_t                        r_mat0,
    output mat_t                        r_mat1,
    output logic                        r_d0,
    output logic                        r_d1,
    output logic                        r_v0,
    output logic                        r_v1,
    // entry arrays are the storage itself
    output logic  [tlb_num-1:0]         entry_e,
    output logic  [tlb_num-1:0]         entry_huge,
    output vppn_t [tlb_num-1:0]         entry_vppn,
    output asid_t [tlb_num-1:0]         entry_asid,
    output logic  [tlb_num-1:0]         entry_g,
    output ppn_t  [tlb_num-1:0]         entry_ppn0,
    output ppn_t  [tlb_num-1:0]         entry_ppn1,
    output plv_t  [tlb_num-1:0]         entry_plv0,
    output plv_t  [tlb_num-1:0]         entry_plv1,
    output mat_t  [tlb_num-1:0]         entry_mat0,
    output mat_t  [tlb_num-1:0]         entry_mat1,
    output logic  [tlb_num-1:0]         entry_d0,
    output logic  [tlb_num-1:0]         entry_d1,
    output logic  [tlb_num-1:0]         entry_v0,
    output logic  [tlb_num-1:0]         entry_v1
);

    logic [tlb_num-1:0] asid_eq;
    logic [tlb_num-1:0] va_eq;
    logic [tlb_num-1:0] inv_clear;

    // per-entry compare against the invalidate operands
    always_comb
    begin
        for (int i = 0; i < tlb_num; i++)
        begin
            asid_eq[i] = (entry_asid[i] == inv_asid);
            va_eq[i]   = vppn_match(entry_vppn[i], entry_huge[i], inv_vppn);
        end
    end

    always_comb
    begin
        case (inv_op)
            inv_all0, inv_all1: inv_clear = '1;
            inv_global:         inv_clear = entry_g;
            inv_nonglobal:      inv_clear = ~entry_g;
            inv_asid:           inv_clear = ~entry_g & asid_eq;
            inv_asid_va:        inv_clear = ~entry_g & asid_eq & va_eq;
            inv_g_or_asid_va:   inv_clear = (entry_g | asid_eq) & va_eq;
            default:            inv_clear = '0;
        endcase
    end

    // write beats invalidate in the same cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            entry_e <= '0;
        else if (we)
            entry_e[w_index] <= w_e;
        else if (inv_valid)
            entry_e <= entry_e & ~inv_clear;
    end

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            entry_vppn[w_index] <= w_vppn;
            // only the 4 MB flag is kept of the page size
            entry_huge[w_index] <= (w_ps == ps_4m);
            entry_asid[w_index] <= w_asid;
            entry_g[w_index]    <= w_g;
            entry_ppn0[w_index] <= w_ppn0;
            entry_ppn1[w_index] <= w_ppn1;
            entry_plv0[w_index] <= w_plv0;
            entry_plv1[w_index] <= w_plv1;
            entry_mat0[w_index] <= w_mat0;
            entry_mat1[w_index] <= w_mat1;
            entry_d0[w_index]   <= w_d0;
            entry_d1[w_index]   <= w_d1;
            entry_v0[w_index]   <= w_v0;
            entry_v1[w_index]   <= w_v1;
        end
    end

    assign r_e    = entry_e[r_index];
    assign r_vppn = entry_vppn[r_index];
    assign r_ps   = entry_huge[r_index] ? ps_4m : ps_4k;
    assign r_asid = entry_asid[r_index];
    assign r_g    = entry_g[r_index];
    assign r_ppn0 = entry_ppn0[r_index];
    assign r_ppn1 = entry_ppn1[r_index];
    assign r_plv0 = entry_plv0[r_index];
    assign r_plv1 = entry_plv1[r_index];
    assign r_mat0 = entry_mat0[r_index];
    assign r_mat1 = entry_mat1[r_index];
    assign r_d0   = entry_d0[r_index];
    assign r_d1   = entry_d1[r_index];
    assign r_v0   = entry_v0[r_index];
    assign r_v1   = entry_v1[r_index];

    // any other size code would be stored as 4 KB and read back wrong
    a_legal_ps: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (w_ps == ps_4k || w_ps == ps_4m));

endmodule

`default_nettype wire

/* verilog/tlb_pkg.sv */
`default_nettype none

package tlb_pkg;

    localparam int tlb_num = 16;

    typedef logic [$clog2(tlb_num)-1:0] tlb_index_t;
    typedef logic [18:0] vppn_t;
    typedef logic [9:0]  asid_t;
    typedef logic [19:0] ppn_t;
    typedef logic [5:0]  ps_t;
    typedef logic [1:0]  plv_t;
    typedef logic [1:0]  mat_t;
    typedef logic [4:0]  inv_op_t;

    // page-size codes, log2 of the page size in bytes
    localparam ps_t ps_4k = 6'd12;
    localparam ps_t ps_4m = 6'd22;

    // a 4 MB double page ignores the low ten vppn bits
    localparam int vppn_huge_lsb = 10;
    localparam int odd_bit_4m    = 9;

    localparam inv_op_t inv_all0         = 5'd0;
    localparam inv_op_t inv_all1         = 5'd1;
    localparam inv_op_t inv_global       = 5'd2;
    localparam inv_op_t inv_nonglobal    = 5'd3;
    localparam inv_op_t inv_asid         = 5'd4;
    localparam inv_op_t inv_asid_va      = 5'd5;
    localparam inv_op_t inv_g_or_asid_va = 5'd6;

    // address part of an entry match, shared by lookup and invalidate
    function automatic logic vppn_match(
        input vppn_t entry_vppn,
        input logic  huge,
        input vppn_t query
    );
        logic hi_eq;
        logic lo_eq;
        hi_eq = (entry_vppn[18:vppn_huge_lsb] == query[18:vppn_huge_lsb]);
        lo_eq = (entry_vppn[vppn_huge_lsb-1:0] == query[vppn_huge_lsb-1:0]);
        return hi_eq && (huge || lo_eq);
    endfunction

endpackage

`default_nettype wire
